// ==== src/core_config.svh ====
// Global sizing for the dual-issue execution datapath
// Include wherever data width, register count or ROB depth is needed

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ------------------------------------------------------------
// Datapath sizing
// ------------------------------------------------------------

// Data word width in bits
`define CORE_XLEN 32

// Architectural integer registers, x0 included
`define CORE_NUM_REGS 32

// Reorder-buffer entries, indexed by a 5-bit slot
`define CORE_ROB_DEPTH 32

`endif

// ==== src/core_pkg.sv ====
// Shared types for the dual-issue datapath
// Words, addresses, ROB slots, ALU and operand-select codes, instruction views

`include "core_config.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [4:0]            reg_addr_t;
  typedef logic [4:0]            rob_slot_t;

  // ALU function codes
  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_and      = 4'd2,
    alu_or       = 4'd3,
    alu_xor      = 4'd4,
    alu_slt      = 4'd5,
    alu_sltu     = 4'd6,
    alu_sll      = 4'd7,
    alu_srl      = 4'd8,
    alu_sra      = 4'd9,
    alu_pass_op1 = 4'd10
  } alu_fn_e;

  // First operand source
  typedef enum logic {
    op0_rs1  = 1'b0,
    op0_zero = 1'b1
  } op0_sel_e;

  // Second operand source, code 3 is unused
  typedef enum logic [2:0] {
    op1_rs2   = 3'd0,
    op1_shamt = 3'd1,
    op1_imm_u = 3'd2,
    op1_imm_i = 3'd4,
    op1_imm_s = 3'd5,
    op1_zero  = 3'd6
  } op1_sel_e;

  // ------------------------------------------------------------
  // Instruction word formats
  // ------------------------------------------------------------

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } inst_s_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_u_t;

  // One 32-bit word seen through each format
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_u_t u;
  } inst_u;

endpackage

// ==== src/inst_field_decode.sv ====
// Instruction field extraction for one issue lane
// Gives source register addresses, shift amount and the I, S and U immediates

`timescale 1ns/1ns

module inst_field_decode (
  input  core_pkg::inst_u     inst_i,
  output core_pkg::reg_addr_t rs1_o,
  output core_pkg::reg_addr_t rs2_o,
  output core_pkg::word_t     shamt_o,
  output core_pkg::word_t     imm_i_o,
  output core_pkg::word_t     imm_s_o,
  output core_pkg::word_t     imm_u_o
);

  import core_pkg::*;

  // Source addresses sit at the same bits in R, I and S formats
  assign rs1_o = inst_i.r.rs1;
  assign rs2_o = inst_i.r.rs2;

  // Shift amount lives in the rs2 field, zero-extended
  assign shamt_o = word_t'(inst_i.r.rs2);

  // ------------------------------------------------------------
  // Immediates
  // ------------------------------------------------------------

  // I-type, 12 bits sign-extended
  assign imm_i_o = word_t'($signed(inst_i.i.imm));

  // S-type, split field rejoined then sign-extended
  assign imm_s_o = word_t'($signed({inst_i.s.imm_hi, inst_i.s.imm_lo}));

  // U-type, upper 20 bits with low zeros
  assign imm_u_o = {inst_i.u.imm, 12'b0};

endmodule

// ==== src/core_alu.sv ====
// Integer ALU used in the execute stage of each lane
// Pure combinational; result follows operands and function code directly

`timescale 1ns/1ns

module core_alu (
  input  core_pkg::word_t   op0_i,
  input  core_pkg::word_t   op1_i,
  input  core_pkg::alu_fn_e fn_i,
  output core_pkg::word_t   result_o
);

  import core_pkg::*;

  logic [4:0] shift_amt;

  // Shifts only look at the low five bits
  assign shift_amt = op1_i[4:0];

  always_comb begin
    case (fn_i)
      alu_add: begin
        result_o = op0_i + op1_i;
      end
      alu_sub: begin
        result_o = op0_i - op1_i;
      end
      alu_and: begin
        result_o = op0_i & op1_i;
      end
      alu_or: begin
        result_o = op0_i | op1_i;
      end
      alu_xor: begin
        result_o = op0_i ^ op1_i;
      end
      alu_slt: begin
        result_o = word_t'($signed(op0_i) < $signed(op1_i));
      end
      alu_sltu: begin
        result_o = word_t'(op0_i < op1_i);
      end
      alu_sll: begin
        result_o = op0_i << shift_amt;
      end
      alu_srl: begin
        result_o = op0_i >> shift_amt;
      end
      alu_sra: begin
        result_o = word_t'($signed(op0_i) >>> shift_amt);
      end
      alu_pass_op1: begin
        result_o = op1_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

// ==== src/issue_lane.sv ====
// One execution lane: decode, operand select, execute and writeback registers
// Instantiate once per lane; the register file is read outside during issue

`timescale 1ns/1ns

module issue_lane (
  input                         clk,
  input                         reset,
  input                         issue_i,
  input  core_pkg::inst_u       inst_i,
  input  core_pkg::op0_sel_e    op0_sel_i,
  input  core_pkg::op1_sel_e    op1_sel_i,
  input  core_pkg::alu_fn_e     alu_fn_i,
  input  core_pkg::rob_slot_t   rob_slot_i,
  output core_pkg::reg_addr_t   rs1_o,
  output core_pkg::reg_addr_t   rs2_o,
  input  core_pkg::word_t       rdata0_i,
  input  core_pkg::word_t       rdata1_i,
  output logic                  x_valid_o,
  output core_pkg::word_t       x_op0_o,
  output core_pkg::word_t       x_op1_o,
  output logic                  wb_valid_o,
  output core_pkg::word_t       wb_result_o,
  output core_pkg::rob_slot_t   wb_slot_o
);

  import core_pkg::*;

  word_t     shamt;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_u;
  word_t     op0_mux;
  word_t     op1_mux;
  alu_fn_e   x_fn;
  rob_slot_t x_slot;
  word_t     alu_out;

  inst_field_decode u_decode (
    .inst_i  (inst_i),
    .rs1_o   (rs1_o),
    .rs2_o   (rs2_o),
    .shamt_o (shamt),
    .imm_i_o (imm_i),
    .imm_s_o (imm_s),
    .imm_u_o (imm_u)
  );

  // ------------------------------------------------------------
  // Issue stage operand muxes
  // ------------------------------------------------------------

  assign op0_mux = (op0_sel_i == op0_zero) ? '0 : rdata0_i;

  always_comb begin
    case (op1_sel_i)
      op1_rs2:   op1_mux = rdata1_i;
      op1_shamt: op1_mux = shamt;
      op1_imm_u: op1_mux = imm_u;
      op1_imm_i: op1_mux = imm_i;
      op1_imm_s: op1_mux = imm_s;
      default:   op1_mux = '0;
    endcase
  end

  // Execute registers, payload loads only on issue
  always_ff @(posedge clk) begin
    if (reset) begin
      x_valid_o <= 1'b0;
    end else begin
      x_valid_o <= issue_i;
    end
    if (issue_i) begin
      x_op0_o <= op0_mux;
      x_op1_o <= op1_mux;
      x_fn    <= alu_fn_i;
      x_slot  <= rob_slot_i;
    end
  end

  core_alu u_alu (
    .op0_i    (x_op0_o),
    .op1_i    (x_op1_o),
    .fn_i     (x_fn),
    .result_o (alu_out)
  );

  // Writeback registers
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= x_valid_o;
    end
    if (x_valid_o) begin
      wb_result_o <= alu_out;
      wb_slot_o   <= x_slot;
    end
  end

endmodule

// ==== src/branch_cond_unit.sv ====
// Branch comparison flags for the execute stage of lane A
// Signed and unsigned compares come from the sign bits and op0 - op1

`timescale 1ns/1ns

module branch_cond_unit (
  input  core_pkg::word_t op0_i,
  input  core_pkg::word_t op1_i,
  output logic            eq_o,
  output logic            ne_o,
  output logic            lt_o,
  output logic            ltu_o,
  output logic            ge_o,
  output logic            geu_o
);

  import core_pkg::*;

  localparam int MSB = $bits(word_t) - 1;

  word_t diff;
  logic  diff_signs;

  assign diff       = op0_i - op1_i;
  assign diff_signs = op0_i[MSB] ^ op1_i[MSB];

  // With differing signs the sign bits alone decide, no overflow to worry about
  assign eq_o  = (diff == '0);
  assign ne_o  = ~eq_o;
  assign lt_o  = diff_signs ? op0_i[MSB] : diff[MSB];
  assign ltu_o = diff_signs ? op1_i[MSB] : diff[MSB];
  assign ge_o  = diff_signs ? op1_i[MSB] : ~diff[MSB];
  assign geu_o = diff_signs ? op0_i[MSB] : ~diff[MSB];

endmodule

// ==== src/core_regfile.sv ====
// Architectural register file, four asynchronous reads and two commit writes
// x0 reads as zero; write port 1 wins when both ports hit one address

`timescale 1ns/1ns

`include "core_config.svh"

module core_regfile (
  input                       clk,
  input                       reset,
  input  core_pkg::reg_addr_t raddr0_i,
  input  core_pkg::reg_addr_t raddr1_i,
  input  core_pkg::reg_addr_t raddr2_i,
  input  core_pkg::reg_addr_t raddr3_i,
  output core_pkg::word_t     rdata0_o,
  output core_pkg::word_t     rdata1_o,
  output core_pkg::word_t     rdata2_o,
  output core_pkg::word_t     rdata3_o,
  input                       wen0_i,
  input                       wen1_i,
  input  core_pkg::reg_addr_t waddr0_i,
  input  core_pkg::reg_addr_t waddr1_i,
  input  core_pkg::word_t     wdata0_i,
  input  core_pkg::word_t     wdata1_i
);

  import core_pkg::*;

  word_t regs [`CORE_NUM_REGS];

  // Reads, x0 forced to zero
  assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
  assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i];

  // Port 1 written last so it overrides port 0
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < `CORE_NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (wen0_i && (waddr0_i != '0)) begin
        regs[waddr0_i] <= wdata0_i;
      end
      if (wen1_i && (waddr1_i != '0)) begin
        regs[waddr1_i] <= wdata1_i;
      end
    end
  end

endmodule

// ==== src/rob_data_buffer.sv ====
// Reorder-buffer result storage
// Filled from both writeback lanes, read combinationally by the two commit ports

`timescale 1ns/1ns

`include "core_config.svh"

module rob_data_buffer (
  input                       clk,
  input                       fill0_en_i,
  input                       fill1_en_i,
  input  core_pkg::rob_slot_t fill0_slot_i,
  input  core_pkg::rob_slot_t fill1_slot_i,
  input  core_pkg::word_t     fill0_data_i,
  input  core_pkg::word_t     fill1_data_i,
  input  core_pkg::rob_slot_t read0_slot_i,
  input  core_pkg::rob_slot_t read1_slot_i,
  output core_pkg::word_t     read0_data_o,
  output core_pkg::word_t     read1_data_o
);

  import core_pkg::*;

  word_t rob_mem [`CORE_ROB_DEPTH];

  // ------------------------------------------------------------
  // Fill from writeback
  // ------------------------------------------------------------

  // Lane B fill comes second so it owns a shared slot
  always_ff @(posedge clk) begin
    if (fill0_en_i) begin
      rob_mem[fill0_slot_i] <= fill0_data_i;
    end
    if (fill1_en_i) begin
      rob_mem[fill1_slot_i] <= fill1_data_i;
    end
  end

  // Commit reads see contents before this edge's fill
  assign read0_data_o = rob_mem[read0_slot_i];
  assign read1_data_o = rob_mem[read1_slot_i];

endmodule

// ==== src/dual_issue_dpath.sv ====
// Dual-issue execution datapath top
// Two lanes share the register file; results pass through the ROB to commit

`timescale 1ns/1ns

module dual_issue_dpath (
  input                       clk,
  input                       reset,
  input                       issue_i,
  input  core_pkg::inst_u     inst_a_i,
  input  core_pkg::inst_u     inst_b_i,
  input  core_pkg::op0_sel_e  op0_sel_a_i,
  input  core_pkg::op0_sel_e  op0_sel_b_i,
  input  core_pkg::op1_sel_e  op1_sel_a_i,
  input  core_pkg::op1_sel_e  op1_sel_b_i,
  input  core_pkg::alu_fn_e   alu_fn_a_i,
  input  core_pkg::alu_fn_e   alu_fn_b_i,
  input  core_pkg::rob_slot_t rob_slot_a_i,
  input  core_pkg::rob_slot_t rob_slot_b_i,
  input                       commit1_en_i,
  input  core_pkg::rob_slot_t commit1_slot_i,
  input  core_pkg::reg_addr_t commit1_waddr_i,
  input                       commit2_en_i,
  input  core_pkg::rob_slot_t commit2_slot_i,
  input  core_pkg::reg_addr_t commit2_waddr_i,
  output logic                branch_valid_o,
  output logic                br_eq_o,
  output logic                br_ne_o,
  output logic                br_lt_o,
  output logic                br_ltu_o,
  output logic                br_ge_o,
  output logic                br_geu_o,
  output logic                wb_valid_o,
  output core_pkg::word_t     result_a_o,
  output core_pkg::word_t     result_b_o
);

  import core_pkg::*;

  reg_addr_t rs1_a;
  reg_addr_t rs2_a;
  reg_addr_t rs1_b;
  reg_addr_t rs2_b;
  word_t     rdata0_a;
  word_t     rdata1_a;
  word_t     rdata0_b;
  word_t     rdata1_b;
  word_t     x_op0_a;
  word_t     x_op1_a;
  logic      wb_valid_b;
  rob_slot_t wb_slot_a;
  rob_slot_t wb_slot_b;
  word_t     commit1_data;
  word_t     commit2_data;

  // ------------------------------------------------------------
  // Lanes
  // ------------------------------------------------------------

  // Lane A also feeds the branch unit and owns the writeback valid
  issue_lane lane_a (
    .clk         (clk),
    .reset       (reset),
    .issue_i     (issue_i),
    .inst_i      (inst_a_i),
    .op0_sel_i   (op0_sel_a_i),
    .op1_sel_i   (op1_sel_a_i),
    .alu_fn_i    (alu_fn_a_i),
    .rob_slot_i  (rob_slot_a_i),
    .rs1_o       (rs1_a),
    .rs2_o       (rs2_a),
    .rdata0_i    (rdata0_a),
    .rdata1_i    (rdata1_a),
    .x_valid_o   (branch_valid_o),
    .x_op0_o     (x_op0_a),
    .x_op1_o     (x_op1_a),
    .wb_valid_o  (wb_valid_o),
    .wb_result_o (result_a_o),
    .wb_slot_o   (wb_slot_a)
  );

  issue_lane lane_b (
    .clk         (clk),
    .reset       (reset),
    .issue_i     (issue_i),
    .inst_i      (inst_b_i),
    .op0_sel_i   (op0_sel_b_i),
    .op1_sel_i   (op1_sel_b_i),
    .alu_fn_i    (alu_fn_b_i),
    .rob_slot_i  (rob_slot_b_i),
    .rs1_o       (rs1_b),
    .rs2_o       (rs2_b),
    .rdata0_i    (rdata0_b),
    .rdata1_i    (rdata1_b),
    .x_valid_o   (),
    .x_op0_o     (),
    .x_op1_o     (),
    .wb_valid_o  (wb_valid_b),
    .wb_result_o (result_b_o),
    .wb_slot_o   (wb_slot_b)
  );

  branch_cond_unit u_branch (
    .op0_i (x_op0_a),
    .op1_i (x_op1_a),
    .eq_o  (br_eq_o),
    .ne_o  (br_ne_o),
    .lt_o  (br_lt_o),
    .ltu_o (br_ltu_o),
    .ge_o  (br_ge_o),
    .geu_o (br_geu_o)
  );

  // ------------------------------------------------------------
  // Register file and ROB
  // ------------------------------------------------------------

  // Commit port 2 maps to write port 1, which has priority
  core_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .raddr0_i (rs1_a),
    .raddr1_i (rs2_a),
    .raddr2_i (rs1_b),
    .raddr3_i (rs2_b),
    .rdata0_o (rdata0_a),
    .rdata1_o (rdata1_a),
    .rdata2_o (rdata0_b),
    .rdata3_o (rdata1_b),
    .wen0_i   (commit1_en_i),
    .wen1_i   (commit2_en_i),
    .waddr0_i (commit1_waddr_i),
    .waddr1_i (commit2_waddr_i),
    .wdata0_i (commit1_data),
    .wdata1_i (commit2_data)
  );

  rob_data_buffer u_rob (
    .clk          (clk),
    .fill0_en_i   (wb_valid_o),
    .fill1_en_i   (wb_valid_b),
    .fill0_slot_i (wb_slot_a),
    .fill1_slot_i (wb_slot_b),
    .fill0_data_i (result_a_o),
    .fill1_data_i (result_b_o),
    .read0_slot_i (commit1_slot_i),
    .read1_slot_i (commit2_slot_i),
    .read0_data_o (commit1_data),
    .read1_data_o (commit2_data)
  );

endmodule

// ==== verif/dual_issue_dpath_tb.sv ====
// Self-checking testbench for the dual-issue execution datapath
// Reference model predicts lane results and branch flags for the assertions

`timescale 1ns/1ns

module dual_issue_dpath_tb;

  import core_pkg::*;

  localparam int MSB = $bits(word_t) - 1;
  localparam int DRAIN_LIMIT = 20;

  typedef struct packed {
    word_t     inst;
    op0_sel_e  op0;
    op1_sel_e  op1;
    alu_fn_e   fn;
    rob_slot_t slot;
  } lane_req_t;

  typedef struct packed {
    word_t     res_a;
    word_t     res_b;
    rob_slot_t slot_a;
    rob_slot_t slot_b;
  } exp_t;

  logic clk = 1'b0;
  logic reset;
  logic issue_i;
  inst_u inst_a;
  inst_u inst_b;
  op0_sel_e op0_sel_a;
  op0_sel_e op0_sel_b;
  op1_sel_e op1_sel_a;
  op1_sel_e op1_sel_b;
  alu_fn_e alu_fn_a;
  alu_fn_e alu_fn_b;
  rob_slot_t rob_slot_a;
  rob_slot_t rob_slot_b;
  logic commit1_en;
  rob_slot_t commit1_slot;
  reg_addr_t commit1_waddr;
  logic commit2_en;
  rob_slot_t commit2_slot;
  reg_addr_t commit2_waddr;
  logic branch_valid_o;
  logic br_eq_o;
  logic br_ne_o;
  logic br_lt_o;
  logic br_ltu_o;
  logic br_ge_o;
  logic br_geu_o;
  logic wb_valid_o;
  word_t result_a_o;
  word_t result_b_o;

  // Model state and expectation queues
  word_t regs_model [32];
  word_t rob_model [32];
  exp_t exp_q [$];
  logic [5:0] br_q [$];
  exp_t wb_head;
  word_t exp_res_a;
  word_t exp_res_b;
  logic [5:0] exp_flags;
  logic issue_d1;
  logic issue_d2;
  integer seed;
  int error_count = 0;
  int timeout_count = 0;
  int issue_count = 0;
  word_t w;

  op1_sel_e imm_sels [4] = '{op1_shamt, op1_imm_u, op1_imm_i, op1_imm_s};
  alu_fn_e imm_fns [4] = '{alu_sra, alu_xor, alu_add, alu_sub};

  dual_issue_dpath UUT (
    .clk             (clk),
    .reset           (reset),
    .issue_i         (issue_i),
    .inst_a_i        (inst_a),
    .inst_b_i        (inst_b),
    .op0_sel_a_i     (op0_sel_a),
    .op0_sel_b_i     (op0_sel_b),
    .op1_sel_a_i     (op1_sel_a),
    .op1_sel_b_i     (op1_sel_b),
    .alu_fn_a_i      (alu_fn_a),
    .alu_fn_b_i      (alu_fn_b),
    .rob_slot_a_i    (rob_slot_a),
    .rob_slot_b_i    (rob_slot_b),
    .commit1_en_i    (commit1_en),
    .commit1_slot_i  (commit1_slot),
    .commit1_waddr_i (commit1_waddr),
    .commit2_en_i    (commit2_en),
    .commit2_slot_i  (commit2_slot),
    .commit2_waddr_i (commit2_waddr),
    .branch_valid_o  (branch_valid_o),
    .br_eq_o         (br_eq_o),
    .br_ne_o         (br_ne_o),
    .br_lt_o         (br_lt_o),
    .br_ltu_o        (br_ltu_o),
    .br_ge_o         (br_ge_o),
    .br_geu_o        (br_geu_o),
    .wb_valid_o      (wb_valid_o),
    .result_a_o      (result_a_o),
    .result_b_o      (result_b_o)
  );

  always #20 clk = ~clk;

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  function automatic word_t expected_alu(word_t a, word_t b, alu_fn_e fn);
    logic [2*$bits(word_t)-1:0] ext;
    case (fn)
      alu_add: return a + b;
      alu_sub: return a + ~b + 1'b1;
      alu_and: return a & b;
      alu_or: return a | b;
      alu_xor: return a ^ b;
      alu_slt: return (a[MSB] != b[MSB]) ? word_t'(a[MSB]) : word_t'(a < b);
      alu_sltu: return word_t'(a < b);
      alu_sll: return a << b[4:0];
      alu_srl: return a >> b[4:0];
      alu_sra: begin
        ext = {{$bits(word_t){a[MSB]}}, a} >> b[4:0];
        return ext[MSB:0];
      end
      alu_pass_op1: return b;
      default: return '0;
    endcase
  endfunction

  function automatic word_t src0_value(lane_req_t q);
    if (q.op0 == op0_zero) return '0;
    return regs_model[q.inst[19:15]];
  endfunction

  // Immediate layouts follow the RISC-V base formats
  function automatic word_t src1_value(lane_req_t q);
    case (q.op1)
      op1_rs2: return regs_model[q.inst[24:20]];
      op1_shamt: return word_t'(q.inst[24:20]);
      op1_imm_u: return {q.inst[31:12], 12'b0};
      op1_imm_i: return {{20{q.inst[31]}}, q.inst[31:20]};
      op1_imm_s: return {{20{q.inst[31]}}, q.inst[31:25], q.inst[11:7]};
      default: return '0;
    endcase
  endfunction

  function automatic lane_req_t make_req(word_t inst, op0_sel_e o0, op1_sel_e o1,
                                         alu_fn_e fn, rob_slot_t slot);
    lane_req_t q;
    q.inst = inst;
    q.op0 = o0;
    q.op1 = o1;
    q.fn = fn;
    q.slot = slot;
    return q;
  endfunction

  function automatic word_t rand_inst(reg_addr_t rs1, reg_addr_t rs2);
    word_t r;
    r = $random(seed);
    r[19:15] = rs1;
    r[24:20] = rs2;
    return r;
  endfunction

  function automatic bit drained();
    return exp_q.size() == 0 && br_q.size() == 0 && !wb_valid_o && !branch_valid_o;
  endfunction

  // ------------------------------------------------------------
  // Drivers called at a falling edge
  // ------------------------------------------------------------

  task automatic apply_issue(lane_req_t ra, lane_req_t rb);
    exp_t e;
    word_t a0;
    word_t a1;
    a0 = src0_value(ra);
    a1 = src1_value(ra);
    e.res_a = expected_alu(a0, a1, ra.fn);
    e.res_b = expected_alu(src0_value(rb), src1_value(rb), rb.fn);
    e.slot_a = ra.slot;
    e.slot_b = rb.slot;
    exp_q.push_back(e);
    br_q.push_back({a0 == a1, a0 != a1, $signed(a0) < $signed(a1), a0 < a1,
                    $signed(a0) >= $signed(a1), a0 >= a1});
    issue_i = 1'b1;
    inst_a = ra.inst;
    op0_sel_a = ra.op0;
    op1_sel_a = ra.op1;
    alu_fn_a = ra.fn;
    rob_slot_a = ra.slot;
    inst_b = rb.inst;
    op0_sel_b = rb.op0;
    op1_sel_b = rb.op1;
    alu_fn_b = rb.fn;
    rob_slot_b = rb.slot;
    issue_count++;
  endtask

  // Model takes the commit after any issue of the same cycle
  task automatic apply_commit(logic en1, rob_slot_t s1, reg_addr_t a1,
                              logic en2, rob_slot_t s2, reg_addr_t a2);
    commit1_en = en1;
    commit1_slot = s1;
    commit1_waddr = a1;
    commit2_en = en2;
    commit2_slot = s2;
    commit2_waddr = a2;
    if (en1 && a1 != 0) regs_model[a1] = rob_model[s1];
    if (en2 && a2 != 0) regs_model[a2] = rob_model[s2];
  endtask

  task automatic step_cycle();
    @(negedge clk);
    issue_i = 1'b0;
    commit1_en = 1'b0;
    commit2_en = 1'b0;
  endtask

  task automatic commit_all();
    for (int r = 0; r < 32; r += 2) begin
      apply_commit(1'b1, 5'(r), 5'(r), 1'b1, 5'(r + 1), 5'(r + 1));
      step_cycle();
    end
  endtask

  task automatic end_run();
    $display("Summary: %0d issues, %0d errors, %0d timeouts",
             issue_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (!drained() && cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!drained()) begin
      timeout_count++;
      $display("Timeout at %0t: pipeline still busy after %0d cycles", $time, DRAIN_LIMIT);
      end_run();
    end
  endtask

  // ------------------------------------------------------------
  // Expectation tracking and checks
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      issue_d1 <= 1'b0;
      issue_d2 <= 1'b0;
    end else begin
      issue_d1 <= issue_i;
      issue_d2 <= issue_d1;
    end
  end

  // Head of each queue is latched mid-cycle
  // ROB model follows fill order
  always @(negedge clk) begin
    if (!reset && wb_valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("Writeback at %0t with no instruction outstanding", $time);
      end else begin
        wb_head = exp_q.pop_front();
        exp_res_a = wb_head.res_a;
        exp_res_b = wb_head.res_b;
        rob_model[wb_head.slot_a] = wb_head.res_a;
        rob_model[wb_head.slot_b] = wb_head.res_b;
      end
    end
    if (!reset && branch_valid_o === 1'b1) begin
      if (br_q.size() == 0) begin
        error_count++;
        $display("Branch flags valid at %0t with nothing in execute", $time);
      end else begin
        exp_flags = br_q.pop_front();
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
      (wb_valid_o == issue_d2) && (branch_valid_o == issue_d1))
    else begin
      error_count++;
      $display("mismatch at %0t: wb_valid %b branch_valid %b, expected %b %b", $time,
               $sampled(wb_valid_o), $sampled(branch_valid_o),
               $sampled(issue_d2), $sampled(issue_d1));
    end

  assert property (@(posedge clk) disable iff (reset)
      wb_valid_o |-> (result_a_o == exp_res_a) && (result_b_o == exp_res_b))
    else begin
      error_count++;
      $display("mismatch at %0t: results %h %h, expected %h %h", $time,
               $sampled(result_a_o), $sampled(result_b_o), exp_res_a, exp_res_b);
    end

  assert property (@(posedge clk) disable iff (reset)
      branch_valid_o |-> ({br_eq_o, br_ne_o, br_lt_o, br_ltu_o, br_ge_o, br_geu_o}
                          == exp_flags))
    else begin
      error_count++;
      $display("mismatch at %0t: branch flags %b, expected %b", $time,
               $sampled({br_eq_o, br_ne_o, br_lt_o, br_ltu_o, br_ge_o, br_geu_o}),
               exp_flags);
    end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  initial begin
    seed = 79534;
    reset = 1'b1;
    issue_i = 1'b0;
    inst_a = '0;
    inst_b = '0;
    op0_sel_a = op0_rs1;
    op0_sel_b = op0_rs1;
    op1_sel_a = op1_rs2;
    op1_sel_b = op1_rs2;
    alu_fn_a = alu_add;
    alu_fn_b = alu_add;
    rob_slot_a = '0;
    rob_slot_b = '0;
    commit1_en = 1'b0;
    commit1_slot = '0;
    commit1_waddr = '0;
    commit2_en = 1'b0;
    commit2_slot = '0;
    commit2_waddr = '0;
    for (int r = 0; r < 32; r++) begin
      regs_model[r] = '0;
      rob_model[r] = '0;
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;

    // Every register reads zero after reset
    for (int r = 0; r < 32; r++) begin
      apply_issue(make_req(rand_inst(5'(r), 5'(r)), op0_rs1, op1_rs2, alu_add, 5'(r)),
                  make_req(rand_inst(5'(r), 5'(31 - r)), op0_rs1, op1_rs2, alu_add,
                           5'(31 - r)));
      step_cycle();
    end
    wait_drain();

    // Upper immediate load then low immediate add, from slot r into register r
    for (int i = 0; i < 16; i++) begin
      apply_issue(make_req(rand_inst(5'd0, 5'd0), op0_zero, op1_imm_u, alu_pass_op1,
                           5'(2 * i)),
                  make_req(rand_inst(5'd0, 5'd0), op0_zero, op1_imm_u, alu_pass_op1,
                           5'(2 * i + 1)));
      step_cycle();
    end
    wait_drain();
    commit_all();
    for (int i = 0; i < 16; i++) begin
      apply_issue(make_req(rand_inst(5'(2 * i), 5'($random(seed))), op0_rs1, op1_imm_i,
                           alu_add, 5'(2 * i)),
                  make_req(rand_inst(5'(2 * i + 1), 5'($random(seed))), op0_rs1, op1_imm_i,
                           alu_add, 5'(2 * i + 1)));
      step_cycle();
    end
    wait_drain();
    commit_all();

    // All ALU functions on register operands
    for (int f = 0; f <= 10; f++) begin
      for (int k = 0; k < 4; k++) begin
        apply_issue(make_req(rand_inst(5'($random(seed)), 5'($random(seed))), op0_rs1,
                             op1_rs2, alu_fn_e'(f), 5'($random(seed))),
                    make_req(rand_inst(5'($random(seed)), 5'($random(seed))), op0_rs1,
                             op1_rs2, alu_fn_e'(f), 5'($random(seed))));
        step_cycle();
      end
    end
    wait_drain();

    // Immediate formats with half of them negative
    for (int k = 0; k < 40; k++) begin
      w = rand_inst(5'($random(seed)), 5'($random(seed)));
      if (k % 8 < 4) w[31] = 1'b1;
      apply_issue(make_req(w, op0_rs1, imm_sels[k % 4], imm_fns[k % 4], 5'(k)),
                  make_req(w ^ 32'h0000_0f80, op0_rs1, imm_sels[(k + 2) % 4],
                           imm_fns[(k + 1) % 4], 5'(k + 7)));
      step_cycle();
    end
    wait_drain();

    // Branch flags with equal operands and negative immediates mixed in
    for (int k = 0; k < 40; k++) begin
      w = rand_inst(5'($random(seed)), 5'($random(seed)));
      if (k % 4 == 0) w[24:20] = w[19:15];
      if (k % 4 == 1) w[31] = 1'b1;
      apply_issue(make_req(w, op0_rs1, (k % 4 == 1) ? op1_imm_i : op1_rs2, alu_sub, 5'(k)),
                  make_req(rand_inst(5'(k), 5'(k + 3)), op0_rs1, op1_rs2, alu_slt,
                           5'(k + 1)));
      step_cycle();
    end
    wait_drain();

    // Commit rules with readers around the commit of slots 0 and 1
    apply_issue(make_req(rand_inst(5'd0, 5'($random(seed))), op0_zero, op1_imm_i, alu_add,
                         5'd0),
                make_req(rand_inst(5'd0, 5'($random(seed))), op0_zero, op1_imm_u,
                         alu_pass_op1, 5'd1));
    step_cycle();
    wait_drain();
    apply_issue(make_req(rand_inst(5'd5, 5'd6), op0_rs1, op1_rs2, alu_or, 5'd20),
                make_req(rand_inst(5'd6, 5'd5), op0_rs1, op1_zero, alu_add, 5'd21));
    apply_commit(1'b1, 5'd0, 5'd5, 1'b1, 5'd1, 5'd6);
    step_cycle();
    apply_issue(make_req(rand_inst(5'd5, 5'd6), op0_rs1, op1_rs2, alu_or, 5'd20),
                make_req(rand_inst(5'd6, 5'd5), op0_rs1, op1_zero, alu_add, 5'd21));
    step_cycle();
    apply_commit(1'b1, 5'd0, 5'd7, 1'b1, 5'd1, 5'd7);
    step_cycle();
    apply_issue(make_req(rand_inst(5'd7, 5'd0), op0_rs1, op1_rs2, alu_add, 5'd22),
                make_req(rand_inst(5'd0, 5'd7), op0_zero, op1_rs2, alu_add, 5'd23));
    apply_commit(1'b1, 5'd0, 5'd0, 1'b0, 5'd0, 5'd0);
    step_cycle();
    apply_issue(make_req(rand_inst(5'd0, 5'd7), op0_rs1, op1_rs2, alu_xor, 5'd24),
                make_req(rand_inst(5'd0, 5'd0), op0_rs1, op1_rs2, alu_or, 5'd25));
    step_cycle();
    wait_drain();

    // Both lanes fill one slot and lane B's word reaches the register
    apply_issue(make_req(rand_inst(5'd0, 5'($random(seed))), op0_zero, op1_imm_i, alu_add,
                         5'd9),
                make_req(rand_inst(5'd0, 5'($random(seed))), op0_zero, op1_imm_u,
                         alu_pass_op1, 5'd9));
    step_cycle();
    wait_drain();
    apply_commit(1'b1, 5'd9, 5'd9, 1'b0, 5'd0, 5'd0);
    step_cycle();
    apply_issue(make_req(rand_inst(5'd9, 5'd0), op0_rs1, op1_zero, alu_add, 5'd10),
                make_req(rand_inst(5'd9, 5'd9), op0_rs1, op1_rs2, alu_or, 5'd11));
    step_cycle();
    wait_drain();
    end_run();
  end

endmodule

// ==== files.f ====
+incdir+src
src/core_pkg.sv
src/inst_field_decode.sv
src/core_alu.sv
src/issue_lane.sv
src/branch_cond_unit.sv
src/core_regfile.sv
src/rob_data_buffer.sv
src/dual_issue_dpath.sv
verif/dual_issue_dpath_tb.sv

// ==== Bender.yml ====
package:
  name: dual_issue_dpath

sources:
  - include_dirs:
      - src
    files:
      - src/core_pkg.sv
      - src/inst_field_decode.sv
      - src/core_alu.sv
      - src/issue_lane.sv
      - src/branch_cond_unit.sv
      - src/core_regfile.sv
      - src/rob_data_buffer.sv
      - src/dual_issue_dpath.sv

  - target: test
    files:
      - verif/dual_issue_dpath_tb.sv
